// File: common/spiPkg.sv
package spiPkg;

	// register map, local to the device
	localparam logic [11:0] configAddress = 12'h000;
	localparam logic [11:0] dataAddress = 12'h004;

	// enable off, chip select active low, msb first, mode 0, scale 4
	localparam logic [8:0] configDefault = 9'h064;

	localparam int dataWidth = 8;
	localparam int clockCounterWidth = 8;

	// transfer FSM encoding
	localparam logic [1:0] stateIdle = 2'd0;
	localparam logic [1:0] stateSetup = 2'd1;
	localparam logic [1:0] stateShift = 2'd2;
	localparam logic [1:0] stateEnd = 2'd3;

	// spiMode[1] is clock polarity, spiMode[0] picks the sample edge
	typedef struct packed {
		logic enable;
		logic activeHighCs;
		logic useCs;
		logic msbFirst;
		logic [1:0] spiMode;
		logic [2:0] clockScale;
	} spiConfigFields_t;

	// bus side sees the raw word, engine side the fields
	typedef union packed {
		logic [8:0] raw;
		spiConfigFields_t fields;
	} spiConfig_u;

	typedef struct packed {
		logic loadEnable;
		logic shiftInEnable;
		logic shiftOutEnable;
	} spiStrobes_t;

	// bus inputs after device decode
	typedef struct packed {
		logic we;
		logic oe;
		logic [3:0] byteSelect;
		logic [11:0] localAddress;
		logic [31:0] dataWrite;
	} busRequest_t;

endpackage

// File: spiRegisters/configurationRegister.sv
`timescale 1ns/1ns

module configurationRegister
	import spiPkg::*;
(
	input logic clk,
	input logic rst,
	input logic enable,
	input busRequest_t request,
	output logic [31:0] dataRead,
	output logic requestOutput,
	output spiConfig_u configuration
);

	logic addressHit;
	logic writeHit;
	logic [31:0] currentWord;
	logic [31:0] mergedWord;

	assign addressHit = enable && (request.localAddress == configAddress);
	assign writeHit = addressHit && request.we;
	assign currentWord = 32'(configuration.raw);

	// only selected lanes replace the stored bytes
	always_comb begin
		mergedWord = currentWord;
		for (int lane = 0; lane < 4; lane++) begin
			if (request.byteSelect[lane]) begin
				mergedWord[lane*8 +: 8] = request.dataWrite[lane*8 +: 8];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			configuration.raw <= configDefault;
		end else if (writeHit) begin
			configuration.raw <= mergedWord[8:0];
		end
	end

	assign requestOutput = addressHit && request.oe;
	assign dataRead = requestOutput ? currentWord : 32'h0;

endmodule

// File: spiRegisters/dataRegister.sv
`timescale 1ns/1ns

module dataRegister
	import spiPkg::*;
(
	input logic clk,
	input logic rst,
	input logic enable,
	input busRequest_t request,
	input logic [dataWidth-1:0] receivedData,
	output logic [31:0] dataRead,
	output logic requestOutput,
	output logic [dataWidth-1:0] writeData,
	output logic writeStrobe
);

	logic addressHit;
	logic writeHit;

	assign addressHit = enable && (request.localAddress == dataAddress);

	// a transfer needs the low byte, other lanes alone do nothing
	assign writeHit = addressHit && request.we && request.byteSelect[0];

	always_ff @(posedge clk) begin
		if (rst) begin
			writeStrobe <= 1'b0;
		end else begin
			writeStrobe <= writeHit;
		end
	end

	always_ff @(posedge clk) begin
		if (writeHit) begin
			writeData <= request.dataWrite[dataWidth-1:0];
		end
	end

	// read back whatever the shift register holds now
	assign requestOutput = addressHit && request.oe;
	assign dataRead = requestOutput ? 32'(receivedData) : 32'h0;

endmodule

// File: spiEngine/spiClockGenerator.sv
`timescale 1ns/1ns

module spiClockGenerator
	import spiPkg::*;
(
	input logic clk,
	input logic rst,
	input logic start,
	input spiConfig_u configuration,
	output spiStrobes_t strobes,
	output logic busy,
	output logic spiClockLevel
);

	logic [1:0] state;
	logic [2:0] bitCounter;
	logic [clockCounterWidth-1:0] clockCounter;
	logic [clockCounterWidth-1:0] halfPeriodLast;
	logic [clockCounterWidth-1:0] fullPeriodLast;
	logic halfDone;
	logic fullDone;
	logic polarity;
	logic sampleMode;
	logic sampleLeading;
	logic spiRise;
	logic spiFall;
	logic sampleEdge;
	logic shiftEdge;

	assign polarity = configuration.fields.spiMode[1];
	assign sampleMode = configuration.fields.spiMode[0];

	// half period is 2^clockScale cycles
	assign halfPeriodLast = (clockCounterWidth'(1) << configuration.fields.clockScale) - 1'b1;
	assign fullPeriodLast = {halfPeriodLast[clockCounterWidth-2:0], 1'b1};
	assign halfDone = clockCounter == halfPeriodLast;
	assign fullDone = clockCounter == fullPeriodLast;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= stateIdle;
			bitCounter <= 3'd0;
			clockCounter <= '0;
			spiClockLevel <= 1'b0;
		end else begin
			case (state)
				stateIdle: begin
					bitCounter <= 3'd0;
					clockCounter <= '0;
					if (start) begin
						state <= stateSetup;
					end
				end
				stateSetup: begin
					if (halfDone) begin
						clockCounter <= '0;
						state <= stateShift;
					end else begin
						clockCounter <= clockCounter + 1'b1;
					end
				end
				stateShift: begin
					if (fullDone) begin
						clockCounter <= '0;
						spiClockLevel <= 1'b0;
						bitCounter <= bitCounter + 1'b1;
						if (bitCounter == 3'd7) begin
							state <= stateEnd;
						end
					end else begin
						clockCounter <= clockCounter + 1'b1;
						if (halfDone) begin
							spiClockLevel <= 1'b1;
						end
					end
				end
				default: begin
					// trailing half period, clock back at idle level
					if (halfDone) begin
						state <= stateIdle;
					end else begin
						clockCounter <= clockCounter + 1'b1;
					end
				end
			endcase
		end
	end

	// edges of the pin clock, leading edge at the half point
	assign spiRise = (state == stateShift) && (polarity ? fullDone : halfDone);
	assign spiFall = (state == stateShift) && (polarity ? halfDone : fullDone);
	assign sampleEdge = sampleMode ? spiFall : spiRise;
	assign shiftEdge = sampleMode ? spiRise : spiFall;
	assign sampleLeading = polarity == sampleMode;

	assign strobes.loadEnable = (state == stateIdle) && start;
	assign strobes.shiftInEnable = sampleEdge;

	// trailing-edge sampling: first leading shift is skipped, last one lands in the end state
	assign strobes.shiftOutEnable = (shiftEdge && !(halfDone && bitCounter == 3'd0)) ||
		(state == stateEnd && halfDone && !sampleLeading);

	assign busy = (state != stateIdle) || start;

endmodule

// File: spiEngine/shiftRegister.sv
`timescale 1ns/1ns

module shiftRegister
	import spiPkg::*;
(
	input logic clk,
	input logic rst,
	input spiStrobes_t strobes,
	input logic msbFirst,
	input logic [dataWidth-1:0] parallelIn,
	input logic serialIn,
	output logic [dataWidth-1:0] parallelOut,
	output logic serialOut
);

	logic [dataWidth-1:0] shiftData;
	logic sampledBit;

	// sampled bit waits here until the next advance frees its slot
	always_ff @(posedge clk) begin
		if (strobes.shiftInEnable) begin
			sampledBit <= serialIn;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			shiftData <= '0;
		end else if (strobes.loadEnable) begin
			shiftData <= parallelIn;
		end else if (strobes.shiftOutEnable) begin
			if (msbFirst) begin
				shiftData <= {shiftData[dataWidth-2:0], sampledBit};
			end else begin
				shiftData <= {sampledBit, shiftData[dataWidth-1:1]};
			end
		end
	end

	assign parallelOut = shiftData;

	// first bit on the line straight after load
	assign serialOut = msbFirst ? shiftData[dataWidth-1] : shiftData[0];

endmodule

// File: src/spiDevice.sv
`timescale 1ns/1ns

module spiDevice
	import spiPkg::*;
#(
	parameter logic [3:0] deviceId = 4'h0
) (
	input logic clk,
	input logic rst,
	input logic peripheralEnable,
	input logic peripheralBus_we,
	input logic peripheralBus_oe,
	input logic [15:0] peripheralBus_address,
	input logic [3:0] peripheralBus_byteSelect,
	input logic [31:0] peripheralBus_dataWrite,
	output logic [31:0] peripheralBus_dataRead,
	output logic peripheralBus_busy,
	output logic requestOutput,
	output logic spi_en,
	output logic spi_clk,
	output logic spi_mosi,
	output logic spi_cs,
	input logic spi_miso
);

	logic deviceEnable;
	busRequest_t request;
	spiConfig_u configuration;
	spiStrobes_t strobes;
	logic [31:0] configRead;
	logic [31:0] dataReadValue;
	logic configRequest;
	logic dataRequest;
	logic [dataWidth-1:0] writeData;
	logic [dataWidth-1:0] receivedData;
	logic writeStrobe;
	logic busy;
	logic spiClockLevel;
	logic polarity;

	// upper nibble picks the device
	assign deviceEnable = peripheralEnable && (peripheralBus_address[15:12] == deviceId);

	assign request = '{
		we: peripheralBus_we,
		oe: peripheralBus_oe,
		byteSelect: peripheralBus_byteSelect,
		localAddress: peripheralBus_address[11:0],
		dataWrite: peripheralBus_dataWrite
	};

	configurationRegister configRegister_i (
		.clk(clk),
		.rst(rst),
		.enable(deviceEnable),
		.request(request),
		.dataRead(configRead),
		.requestOutput(configRequest),
		.configuration(configuration)
	);

	dataRegister dataRegister_i (
		.clk(clk),
		.rst(rst),
		.enable(deviceEnable),
		.request(request),
		.receivedData(receivedData),
		.dataRead(dataReadValue),
		.requestOutput(dataRequest),
		.writeData(writeData),
		.writeStrobe(writeStrobe)
	);

	spiClockGenerator clockGenerator_i (
		.clk(clk),
		.rst(rst),
		.start(writeStrobe),
		.configuration(configuration),
		.strobes(strobes),
		.busy(busy),
		.spiClockLevel(spiClockLevel)
	);

	shiftRegister shiftRegister_i (
		.clk(clk),
		.rst(rst),
		.strobes(strobes),
		.msbFirst(configuration.fields.msbFirst),
		.parallelIn(writeData),
		.serialIn(spi_miso),
		.parallelOut(receivedData),
		.serialOut(spi_mosi)
	);

	// config wins if both ever matched
	assign requestOutput = configRequest || dataRequest;
	assign peripheralBus_dataRead = configRequest ? configRead :
		dataRequest ? dataReadValue : 32'h0;
	assign peripheralBus_busy = busy;

	assign polarity = configuration.fields.spiMode[1];
	assign spi_clk = busy ? (polarity ^ spiClockLevel) : polarity;
	assign spi_cs = configuration.fields.useCs ?
		(configuration.fields.activeHighCs ? busy : !busy) : 1'b0;
	assign spi_en = configuration.fields.enable;

endmodule

// File: verification/spiDevice_assert.sv
`timescale 1ns/1ns

module spiDevice_assert
	import spiPkg::*;
(
	input logic clk,
	input logic rst,
	input logic [3:0] deviceId,
	input logic peripheralEnable,
	input logic peripheralBus_we,
	input logic [15:0] peripheralBus_address,
	input logic [3:0] peripheralBus_byteSelect,
	input logic [31:0] peripheralBus_dataWrite,
	input logic peripheralBus_busy,
	input logic spi_clk,
	input logic spi_mosi,
	input logic spi_cs,
	input spiConfig_u configuration
);

	int failureCount = 0;
	logic dataWrite;
	logic expectedCs;

	assign dataWrite = peripheralEnable && (peripheralBus_address[15:12] == deviceId) &&
		peripheralBus_we && peripheralBus_byteSelect[0] &&
		(peripheralBus_address[11:0] == dataAddress);

	// selected while busy at the configured level, low when unused
	assign expectedCs = configuration.fields.useCs &&
		(peripheralBus_busy == configuration.fields.activeHighCs);

	idleClock: assert property (@(posedge clk) disable iff (rst)
		!peripheralBus_busy |-> spi_clk == configuration.fields.spiMode[1])
	else begin
		$error("spi_clk left the polarity level while idle");
		failureCount++;
	end

	chipSelect: assert property (@(posedge clk) disable iff (rst) spi_cs == expectedCs)
	else begin
		$error("spi_cs does not follow busy and the chip select settings");
		failureCount++;
	end

	busyAfterWrite: assert property (@(posedge clk) disable iff (rst)
		dataWrite && !peripheralBus_busy |=> peripheralBus_busy)
	else begin
		$error("busy did not rise after a data write");
		failureCount++;
	end

	// load lands one edge after busy rises
	firstBit: assert property (@(posedge clk) disable iff (rst)
		$past(dataWrite && !peripheralBus_busy, 2) |->
		spi_mosi == (configuration.fields.msbFirst ? $past(peripheralBus_dataWrite[7], 2) :
		$past(peripheralBus_dataWrite[0], 2)))
	else begin
		$error("spi_mosi does not carry the first bit of the written byte");
		failureCount++;
	end

endmodule

bind spiDevice spiDevice_assert assertions_i (
	.clk(clk),
	.rst(rst),
	.deviceId(deviceId),
	.peripheralEnable(peripheralEnable),
	.peripheralBus_we(peripheralBus_we),
	.peripheralBus_address(peripheralBus_address),
	.peripheralBus_byteSelect(peripheralBus_byteSelect),
	.peripheralBus_dataWrite(peripheralBus_dataWrite),
	.peripheralBus_busy(peripheralBus_busy),
	.spi_clk(spi_clk),
	.spi_mosi(spi_mosi),
	.spi_cs(spi_cs),
	.configuration(configuration)
);

// File: verification/spiDeviceTb.sv
`timescale 1ns/1ns

module spiDeviceTb;

	// longest transfer is 18 half periods of 128 cycles
	localparam int busyTimeout = 18 * 128 + 64;

	logic clk;
	logic rst;
	logic peripheralEnable;
	logic peripheralBus_we;
	logic peripheralBus_oe;
	logic [15:0] peripheralBus_address;
	logic [3:0] peripheralBus_byteSelect;
	logic [31:0] peripheralBus_dataWrite;
	logic [31:0] peripheralBus_dataRead;
	logic peripheralBus_busy;
	logic requestOutput;
	logic spi_en;
	logic spi_clk;
	logic spi_mosi;
	logic spi_cs;
	logic spi_miso;
	int errorCount;
	int assertionErrors;
	logic [31:0] configModel;

	// loopback, every byte comes straight back
	assign spi_miso = spi_mosi;

	spiDevice #(
		.deviceId(4'h3)
	) dut_i (
		.clk(clk),
		.rst(rst),
		.peripheralEnable(peripheralEnable),
		.peripheralBus_we(peripheralBus_we),
		.peripheralBus_oe(peripheralBus_oe),
		.peripheralBus_address(peripheralBus_address),
		.peripheralBus_byteSelect(peripheralBus_byteSelect),
		.peripheralBus_dataWrite(peripheralBus_dataWrite),
		.peripheralBus_dataRead(peripheralBus_dataRead),
		.peripheralBus_busy(peripheralBus_busy),
		.requestOutput(requestOutput),
		.spi_en(spi_en),
		.spi_clk(spi_clk),
		.spi_mosi(spi_mosi),
		.spi_cs(spi_cs),
		.spi_miso(spi_miso)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("FAILED %s: expected 0x%h, got 0x%h", name, expected, actual);
			errorCount++;
		end
	endtask

	task automatic busWrite(input logic [15:0] address, input logic [3:0] lanes,
		input logic [31:0] data);
		@(posedge clk);
		peripheralEnable <= 1'b1;
		peripheralBus_we <= 1'b1;
		peripheralBus_address <= address;
		peripheralBus_byteSelect <= lanes;
		peripheralBus_dataWrite <= data;
		@(posedge clk);
		peripheralEnable <= 1'b0;
		peripheralBus_we <= 1'b0;
		peripheralBus_byteSelect <= 4'h0;
	endtask

	// combinational read, sampled mid cycle
	task automatic busRead(input logic [15:0] address, input logic expectRequest,
		input logic [31:0] expected);
		@(posedge clk);
		peripheralEnable <= 1'b1;
		peripheralBus_oe <= 1'b1;
		peripheralBus_address <= address;
		@(negedge clk);
		checkValue("requestOutput", {31'h0, requestOutput}, {31'h0, expectRequest});
		checkValue("peripheralBus_dataRead", peripheralBus_dataRead, expected);
		@(posedge clk);
		peripheralEnable <= 1'b0;
		peripheralBus_oe <= 1'b0;
	endtask

	task automatic waitWhileBusy();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (peripheralBus_busy && cycles < busyTimeout) begin
			@(negedge clk);
			cycles++;
		end
		if (peripheralBus_busy) begin
			$display("transfer did not finish: busy still high after %0d cycles", cycles);
			errorCount++;
		end
	endtask

	function automatic logic [31:0] mergeLanes(input logic [31:0] previous,
		input logic [3:0] lanes, input logic [31:0] data);
		logic [31:0] laneMask;
		laneMask = {{8{lanes[3]}}, {8{lanes[2]}}, {8{lanes[1]}}, {8{lanes[0]}}};
		return ((previous & ~laneMask) | (data & laneMask)) & 32'h1ff;
	endfunction

	// enable, activeHighCs, useCs, msbFirst, spiMode, clockScale
	function automatic logic [31:0] configWord(input logic useCs, input logic activeHighCs,
		input logic msbFirst, input logic [1:0] mode, input logic [2:0] scale);
		return {23'h0, 1'b1, activeHighCs, useCs, msbFirst, mode, scale};
	endfunction

	initial begin
		logic [31:0] randomData;
		logic [3:0] lanes;
		logic [7:0] txByte;
		logic [31:0] word;
		void'($urandom(32'h53841c24));
		rst = 1'b1;
		peripheralEnable = 1'b0;
		peripheralBus_we = 1'b0;
		peripheralBus_oe = 1'b0;
		peripheralBus_address = 16'h0;
		peripheralBus_byteSelect = 4'h0;
		peripheralBus_dataWrite = 32'h0;
		errorCount = 0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;

		busRead(16'h3000, 1'b1, 32'h064);
		@(negedge clk);
		checkValue("spi_en", {31'h0, spi_en}, 32'h0);
		checkValue("peripheralBus_busy", {31'h0, peripheralBus_busy}, 32'h0);
		// other device nibble
		busRead(16'h5000, 1'b0, 32'h0);

		configModel = 32'h064;
		repeat (12) begin
			randomData = $urandom;
			lanes = 4'($urandom);
			busWrite(16'h3000, lanes, randomData);
			configModel = mergeLanes(configModel, lanes, randomData);
			busRead(16'h3000, 1'b1, configModel);
		end

		for (int mode = 0; mode < 4; mode++) begin
			for (int order = 0; order < 2; order++) begin
				for (int scaleSel = 0; scaleSel < 2; scaleSel++) begin
					word = configWord(mode != 3, order[0] ^ mode[0], order[0], mode[1:0],
						scaleSel[0] ? 3'd2 : 3'd0);
					busWrite(16'h3000, 4'b0011, word);
					txByte = 8'($urandom);
					busWrite(16'h3004, 4'b0001, {24'h0, txByte});
					waitWhileBusy();
					busRead(16'h3004, 1'b1, {24'h0, txByte});
					checkValue("spi_en", {31'h0, spi_en}, 32'h1);
				end
			end
		end

		@(negedge clk);
		assertionErrors = dut_i.assertions_i.failureCount;
		$display("errors: %0d value or timeout, %0d assertion", errorCount, assertionErrors);
		if (errorCount == 0 && assertionErrors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// File: all.f
common/spiPkg.sv
spiRegisters/configurationRegister.sv
spiRegisters/dataRegister.sv
spiEngine/spiClockGenerator.sv
spiEngine/shiftRegister.sv
src/spiDevice.sv
verification/spiDevice_assert.sv
verification/spiDeviceTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= spiDeviceTb
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert -Wall
SIM_ARGS ?= +verilator+error+limit+1000
PASS_TEXT ?= SIMULATION PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
